// File: all.f
+incdir+include
verilog/dmaReqPkg.sv
verilog/cmdRouter.sv
verilog/entryQueue.sv
verilog/descriptorWriter.sv
verilog/dmaRequestTop.sv
bench/dmaRequest_assertions.sv
bench/dmaRequestTb.sv

// File: bench/dmaRequestTb.sv
`timescale 1ns/1ps
`include "dmaReq_defs.svh"

module dmaRequestTb;

   import dmaReqPkg::*;

   // cycles one command may wait for a credit
   localparam int acceptTimeout  = 200;
   // cycles for all pending words to leave
   localparam int drainTimeout   = 4000;
   localparam int randomCommands = 40;
   // one slave beat is {address, data}
   localparam int beatWidth      = `SLAVE_ADDR_WIDTH + `SLAVE_DATA_WIDTH;

   logic                         clock;
   logic                         reset;
   logic                         cmdValid;
   dmaOpcode_t                   cmdOpcode;
   logic [`HOST_ADDR_WIDTH-1:0]  cmdAddress;
   logic [`COUNT_WIDTH-1:0]      cmdCount;
   logic                         rdWaitRequest;
   logic                         wrWaitRequest;
   logic                         cmdReady;
   logic                         rdChipSelect;
   logic                         rdWrite;
   logic [`SLAVE_ADDR_WIDTH-1:0] rdAddress;
   logic [`SLAVE_DATA_WIDTH-1:0] rdWriteData;
   logic                         wrChipSelect;
   logic                         wrWrite;
   logic [`SLAVE_ADDR_WIDTH-1:0] wrAddress;
   logic [`SLAVE_DATA_WIDTH-1:0] wrWriteData;

   // stall pattern controls
   logic   randomStalls;
   logic   holdRead;
   integer seed;
   int     errorCount;

   // expected beats per slave, oldest first
   logic [beatWidth-1:0] rdExpected[$];
   logic [beatWidth-1:0] wrExpected[$];

   dmaRequestTop DUT (
      .clock(clock), .reset(reset), .cmdValid(cmdValid), .cmdOpcode(cmdOpcode),
      .cmdAddress(cmdAddress), .cmdCount(cmdCount),
      .rdWaitRequest(rdWaitRequest), .wrWaitRequest(wrWaitRequest), .cmdReady(cmdReady),
      .rdChipSelect(rdChipSelect), .rdWrite(rdWrite), .rdAddress(rdAddress),
      .rdWriteData(rdWriteData), .wrChipSelect(wrChipSelect), .wrWrite(wrWrite),
      .wrAddress(wrAddress), .wrWriteData(wrWriteData)
   );

   always #2 clock = ~clock;

   // descriptor word by index: status halves, host address halves, count minus one
   function automatic logic [`SLAVE_DATA_WIDTH-1:0] expectedWord(
      input dmaOpcode_t                  op,
      input logic [`HOST_ADDR_WIDTH-1:0] addr,
      input logic [`COUNT_WIDTH-1:0]     count,
      input int                          index
   );
      logic [63:0] status;
      logic [31:0] word;
      status = (op == opRead) ? `RD_STATUS_ADDR : `WR_STATUS_ADDR;
      case (index)
         0:       word = status[31:0];
         1:       word = status[63:32];
         2:       word = addr[31:0];
         3:       word = addr[63:32];
         // minus one modulo 8, so count 0 gives 7
         default: word = (32'(count) + 32'd7) % 32'd8;
      endcase
      return word;
   endfunction

   task automatic stopWithFailure();
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
      if (actual !== expected) begin
         errorCount++;
         $display("ERR %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
         stopWithFailure();
      end
   endtask

   // rising edge, then the drive offset
   task automatic stepCycle();
      @(posedge clock);
      #1;
   endtask

   // holds the command until it is taken, then books its five words
   task automatic sendCommand(input dmaOpcode_t op, input logic [63:0] addr,
                              input logic [2:0] count, output int stalls);
      int index;
      stalls     = 0;
      cmdValid   = 1'b1;
      cmdOpcode  = op;
      cmdAddress = addr;
      cmdCount   = count;
      @(negedge clock);
      while (!cmdReady) begin
         stalls++;
         if (stalls > acceptTimeout) begin
            $display("timeout, command not accepted after %0d cycles", stalls);
            stopWithFailure();
         end
         @(negedge clock);
      end
      for (index = 0; index < 5; index++) begin
         if (op == opRead) begin
            rdExpected.push_back({8'(index * 4), expectedWord(op, addr, count, index)});
         end else begin
            wrExpected.push_back({8'(index * 4), expectedWord(op, addr, count, index)});
         end
      end
      stepCycle();
      cmdValid = 1'b0;
   endtask

   task automatic waitForDrain();
      int cycles;
      cycles = 0;
      while (rdExpected.size() != 0 || wrExpected.size() != 0) begin
         cycles++;
         if (cycles > drainTimeout) begin
            $display("timeout, descriptor words never arrived, rd %0d and wr %0d left",
                     rdExpected.size(), wrExpected.size());
            stopWithFailure();
         end
         stepCycle();
      end
      // writers back to idle
      repeat (2) stepCycle();
   endtask

   // waitRequest patterns
   // picked on the edge, driven just after it
   always @(posedge clock) begin
      logic rdStall;
      logic wrStall;
      rdStall = 1'b0;
      wrStall = 1'b0;
      if (holdRead) begin
         rdStall = 1'b1;
      end else if (randomStalls) begin
         rdStall = ($random(seed) & 1) != 0;
      end
      if (randomStalls) begin
         wrStall = ($random(seed) & 1) != 0;
      end
      #1;
      rdWaitRequest = rdStall;
      wrWaitRequest = wrStall;
   end

   // scoreboard, checks each beat just before the edge that takes it
   always @(negedge clock) begin
      logic [beatWidth-1:0] beat;
      if (reset) begin
         if (rdWrite && !rdWaitRequest) begin
            if (rdExpected.size() == 0) begin
               $display("rd slave took a word with no read command pending");
               stopWithFailure();
            end else begin
               beat = rdExpected.pop_front();
               checkValue(rdWriteData, beat[`SLAVE_DATA_WIDTH-1:0], "rd slave data");
               checkValue(rdAddress, beat[beatWidth-1:`SLAVE_DATA_WIDTH], "rd slave address");
            end
         end
         if (wrWrite && !wrWaitRequest) begin
            if (wrExpected.size() == 0) begin
               $display("wr slave took a word with no write command pending");
               stopWithFailure();
            end else begin
               beat = wrExpected.pop_front();
               checkValue(wrWriteData, beat[`SLAVE_DATA_WIDTH-1:0], "wr slave data");
               checkValue(wrAddress, beat[beatWidth-1:`SLAVE_DATA_WIDTH], "wr slave address");
            end
         end
      end
   end

   initial begin
      int                          stalls;
      int                          gap;
      int                          n;
      dmaOpcode_t                  op;
      logic [`HOST_ADDR_WIDTH-1:0] addr;
      clock         = 1'b0;
      reset         = 1'b0;
      cmdValid      = 1'b0;
      cmdOpcode     = opRead;
      cmdAddress    = '0;
      cmdCount      = '0;
      rdWaitRequest = 1'b0;
      wrWaitRequest = 1'b0;
      randomStalls  = 1'b0;
      holdRead      = 1'b0;
      seed          = 32'h924d97d8;
      errorCount    = 0;
      repeat (2) @(posedge clock);
      #1;
      reset = 1'b1;

      // reset state
      @(negedge clock);
      checkValue(rdWrite, 1'b0, "rd write after reset");
      checkValue(rdChipSelect, 1'b0, "rd chipSelect after reset");
      checkValue(wrWrite, 1'b0, "wr write after reset");
      checkValue(wrChipSelect, 1'b0, "wr chipSelect after reset");
      checkValue(cmdReady, 1'b1, "cmdReady after reset");
      stepCycle();

      // routing and descriptor content, no stalls
      sendCommand(opRead, 64'h0123_4567_89ab_cdef, 3'd4, stalls);
      // count 0 wraps to 7
      sendCommand(opWrite, 64'hfedc_ba98_7654_3210, 3'd0, stalls);
      sendCommand(opRead, 64'h0000_0001_0000_0000, 3'd1, stalls);
      sendCommand(opWrite, 64'hffff_ffff_ffff_ffff, 3'd7, stalls);
      waitForDrain();

      // random traffic under random waitRequest
      randomStalls = 1'b1;
      for (n = 0; n < randomCommands; n++) begin
         op         = dmaOpcode_t'($random(seed) & 1);
         addr[63:32] = $random(seed);
         addr[31:0]  = $random(seed);
         sendCommand(op, addr, 3'($random(seed)), stalls);
         gap = $random(seed) & 3;
         repeat (gap) stepCycle();
      end
      waitForDrain();
      randomStalls = 1'b0;

      // read slave stuck, credits run out after one queue's worth
      holdRead = 1'b1;
      repeat (2) stepCycle();
      for (n = 0; n < `QUEUE_DEPTH; n++) begin
         sendCommand(opRead, 64'h0000_00a0_0000_0000 + 64'(n * 64), 3'(n), stalls);
         checkValue(stalls, 0, "read stalled before the queue filled");
      end
      cmdValid  = 1'b1;
      cmdOpcode = opRead;
      repeat (6) begin
         @(negedge clock);
         checkValue(cmdReady, 1'b0, "cmdReady for a read with no credit");
      end
      stepCycle();
      cmdValid = 1'b0;
      // write side still has its own credits
      for (n = 0; n < 3; n++) begin
         sendCommand(opWrite, 64'h0000_00b0_0000_1000 + 64'(n), 3'(n + 5), stalls);
         checkValue(stalls, 0, "write held back by read stall");
      end
      // first read descriptor word still offered and held
      checkValue(rdWrite, 1'b1, "rd write while stalled");
      checkValue({rdAddress, rdWriteData}, rdExpected[0], "rd slave word held while stalled");
      holdRead = 1'b0;
      waitForDrain();

      if (errorCount == 0 && rdExpected.size() == 0 && wrExpected.size() == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("descriptor words left over at the end of the run");
         stopWithFailure();
      end
   end

endmodule

// File: bench/dmaRequest_assertions.sv
`timescale 1ns/1ps
`include "dmaReq_defs.svh"

module dmaRequest_assertions (
   input logic                         clock,
   input logic                         reset,
   input logic                         cmdReady,
   input logic                         rdChipSelect,
   input logic                         rdWrite,
   input logic [`SLAVE_ADDR_WIDTH-1:0] rdAddress,
   input logic [`SLAVE_DATA_WIDTH-1:0] rdWriteData,
   input logic                         rdWaitRequest,
   input logic                         wrChipSelect,
   input logic                         wrWrite,
   input logic [`SLAVE_ADDR_WIDTH-1:0] wrAddress,
   input logic [`SLAVE_DATA_WIDTH-1:0] wrWriteData,
   input logic                         wrWaitRequest
);

   // chip select mirrors write on both slaves
   rdSelectMatch: assert property (@(posedge clock) disable iff (!reset)
      rdChipSelect == rdWrite)
      else $error("rd slave chipSelect differs from write");
   wrSelectMatch: assert property (@(posedge clock) disable iff (!reset)
      wrChipSelect == wrWrite)
      else $error("wr slave chipSelect differs from write");

   // a stalled word keeps its address and data
   rdHoldStable: assert property (@(posedge clock) disable iff (!reset)
      rdWrite && rdWaitRequest |=> $stable(rdAddress) && $stable(rdWriteData))
      else $error("rd slave word changed under waitRequest");
   wrHoldStable: assert property (@(posedge clock) disable iff (!reset)
      wrWrite && wrWaitRequest |=> $stable(wrAddress) && $stable(wrWriteData))
      else $error("wr slave word changed under waitRequest");

   // queues start empty, so every credit is there
   readyAfterReset: assert property (@(posedge clock)
      $rose(reset) |-> cmdReady && !rdWrite && !wrWrite)
      else $error("cmdReady low or a slave busy right after reset");

endmodule

bind dmaRequestTop dmaRequest_assertions checks (
   .clock(clock), .reset(reset), .cmdReady(cmdReady),
   .rdChipSelect(rdChipSelect), .rdWrite(rdWrite), .rdAddress(rdAddress),
   .rdWriteData(rdWriteData), .rdWaitRequest(rdWaitRequest),
   .wrChipSelect(wrChipSelect), .wrWrite(wrWrite), .wrAddress(wrAddress),
   .wrWriteData(wrWriteData), .wrWaitRequest(wrWaitRequest)
);

// File: include/dmaReq_defs.svh
`ifndef DMAREQ_DEFS_SVH
`define DMAREQ_DEFS_SVH

// queue entry layout
`define ENTRY_WIDTH      116
`define ENTRY_ADDR_LSB   0
`define ENTRY_ADDR_MSB   63
// transfer count sits high in the entry
`define ENTRY_COUNT_LSB  108
`define ENTRY_COUNT_MSB  110

// command side widths
`define HOST_ADDR_WIDTH  64
`define COUNT_WIDTH      3

// descriptor slave bus
`define SLAVE_ADDR_WIDTH 8
`define SLAVE_DATA_WIDTH 32

// entries held per queue
`define QUEUE_DEPTH      8
// wide enough to hold QUEUE_DEPTH itself
`define CREDIT_WIDTH     4

// status writeback targets, one per DMA engine
`define RD_STATUS_ADDR   64'h0000_0000_0000_6000
`define WR_STATUS_ADDR   64'h0000_0000_0000_7000

`endif

// File: verilog/cmdRouter.sv
`timescale 1ns/1ps
`include "dmaReq_defs.svh"

module cmdRouter (
   input  logic                        clock,
   input  logic                        reset,
   input  logic                        cmdValid,
   input  dmaReqPkg::dmaOpcode_t       cmdOpcode,
   input  logic [`HOST_ADDR_WIDTH-1:0] cmdAddress,
   input  logic [`COUNT_WIDTH-1:0]     cmdCount,
   input  logic                        sqCredit,
   input  logic                        rqCredit,
   output logic                        cmdReady,
   output logic                        sqPush,
   output logic [`ENTRY_WIDTH-1:0]     sqEntry,
   output logic                        rqPush,
   output logic [`ENTRY_WIDTH-1:0]     rqEntry
);

   import dmaReqPkg::*;

   // every queue starts out empty, so all its slots are available
   localparam logic [`CREDIT_WIDTH-1:0] fullCredit = `QUEUE_DEPTH;

   logic [`CREDIT_WIDTH-1:0] sqCredits;
   logic [`CREDIT_WIDTH-1:0] rqCredits;
   logic                     accept;
   logic                     sqTake;
   logic                     rqTake;
   logic [`ENTRY_WIDTH-1:0]  newEntry;
   logic [`ENTRY_WIDTH-1:0]  entryReg;

   // one credit out per command taken, one back per credit pulse
   function automatic logic [`CREDIT_WIDTH-1:0] nextCredit(
      input logic [`CREDIT_WIDTH-1:0] current,
      input logic                     take,
      input logic                     give
   );
      logic [`CREDIT_WIDTH-1:0] result;
      result = current;
      if (take && !give) begin
         result = current - 1'b1;
      end else if (give && !take) begin
         result = current + 1'b1;
      end
      return result;
   endfunction

   // ready follows the credits of the queue the opcode selects
   assign cmdReady = (cmdOpcode == opRead) ? (sqCredits != '0) : (rqCredits != '0);
   assign accept   = cmdValid & cmdReady;
   assign sqTake   = accept & (cmdOpcode == opRead);
   assign rqTake   = accept & (cmdOpcode == opWrite);

   // pack address and count, unused bits stay zero
   always_comb begin
      newEntry = '0;
      newEntry[`ENTRY_ADDR_MSB:`ENTRY_ADDR_LSB]   = cmdAddress;
      newEntry[`ENTRY_COUNT_MSB:`ENTRY_COUNT_LSB] = cmdCount;
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         sqCredits <= fullCredit;
         rqCredits <= fullCredit;
      end else begin
         sqCredits <= nextCredit(sqCredits, sqTake, sqCredit);
         rqCredits <= nextCredit(rqCredits, rqTake, rqCredit);
      end
   end

   // push one cycle after acceptance
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         sqPush <= 1'b0;
         rqPush <= 1'b0;
      end else begin
         sqPush <= sqTake;
         rqPush <= rqTake;
      end
   end

   // payload only, qualified by the push strobes
   always_ff @(posedge clock) begin
      if (accept) begin
         entryReg <= newEntry;
      end
   end

   // both queues see the same register, only one push fires
   assign sqEntry = entryReg;
   assign rqEntry = entryReg;

endmodule

// File: verilog/descriptorWriter.sv
`timescale 1ns/1ps
`include "dmaReq_defs.svh"

module descriptorWriter #(
   parameter logic [`HOST_ADDR_WIDTH-1:0] statusAddress = '0
) (
   input  logic                         clock,
   input  logic                         reset,
   input  logic [`ENTRY_WIDTH-1:0]      entry,
   input  logic                         empty,
   input  logic                         waitRequest,
   output logic                         pop,
   output logic                         chipSelect,
   output logic                         write,
   output logic [`SLAVE_ADDR_WIDTH-1:0] address,
   output logic [`SLAVE_DATA_WIDTH-1:0] writeData
);

   import dmaReqPkg::*;

   descWord_t                   wordState;
   descWord_t                   nextState;
   logic                        wordDone;
   logic [`HOST_ADDR_WIDTH-1:0] hostAddress;
   logic [`COUNT_WIDTH-1:0]     entryCount;
   logic [`COUNT_WIDTH-1:0]     countM1;

   // head entry fields
   assign hostAddress = entry[`ENTRY_ADDR_MSB:`ENTRY_ADDR_LSB];
   assign entryCount  = entry[`ENTRY_COUNT_MSB:`ENTRY_COUNT_LSB];

   // engine counts from zero
   // a count of zero wraps to seven
   assign countM1 = entryCount - 1'b1;

   // a word moves on the edge where write is up and the slave is not stalling
   assign wordDone = write & ~waitRequest;

   // next state
   always_comb begin
      nextState = wordState;
      case (wordState)
         descIdle: begin
            // head is valid whenever the queue is not empty
            if (!empty) begin
               nextState = word0;
            end
         end
         word0: begin
            if (wordDone) begin
               nextState = word1;
            end
         end
         word1: begin
            if (wordDone) begin
               nextState = word2;
            end
         end
         word2: begin
            if (wordDone) begin
               nextState = word3;
            end
         end
         word3: begin
            if (wordDone) begin
               nextState = word4;
            end
         end
         word4: begin
            // always one idle cycle between descriptors
            if (wordDone) begin
               nextState = descIdle;
            end
         end
         default: begin
            nextState = descIdle;
         end
      endcase
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         wordState <= descIdle;
      end else begin
         wordState <= nextState;
      end
   end

   // slave strobes
   assign write      = (wordState != descIdle);
   assign chipSelect = write;

   // entry leaves the queue with the last word
   assign pop = (wordState == word4) & ~waitRequest;

   // state encoding is the word index, times four for bytes
   assign address = {{(`SLAVE_ADDR_WIDTH - 5){1'b0}}, wordState, 2'b00};

   // word data
   // stays put under waitRequest since the head is not popped yet
   always_comb begin
      case (wordState)
         word0:   writeData = statusAddress[31:0];
         word1:   writeData = statusAddress[63:32];
         word2:   writeData = hostAddress[31:0];
         word3:   writeData = hostAddress[63:32];
         word4:   writeData = {{(`SLAVE_DATA_WIDTH - `COUNT_WIDTH){1'b0}}, countM1};
         default: writeData = '0;
      endcase
   end

endmodule

// File: verilog/dmaReqPkg.sv
package dmaReqPkg;

   // command opcode
   // reads go to the submission queue, writes to the request queue
   typedef enum logic {
      opRead  = 1'b0,
      opWrite = 1'b1
   } dmaOpcode_t;

   // descriptor writer state
   // word states double as the slave word index,
   // so the byte address is just the state shifted left by two
   typedef enum logic [2:0] {
      // status address, low half
      word0    = 3'd0,
      // status address, high half
      word1    = 3'd1,
      // host address, low half
      word2    = 3'd2,
      // host address, high half
      word3    = 3'd3,
      // count minus one
      word4    = 3'd4,
      // waiting for a queue entry
      descIdle = 3'd5
   } descWord_t;

endpackage

// File: verilog/dmaRequestTop.sv
`timescale 1ns/1ps
`include "dmaReq_defs.svh"

module dmaRequestTop (
   input  logic                         clock,
   input  logic                         reset,
   input  logic                         cmdValid,
   input  dmaReqPkg::dmaOpcode_t        cmdOpcode,
   input  logic [`HOST_ADDR_WIDTH-1:0]  cmdAddress,
   input  logic [`COUNT_WIDTH-1:0]      cmdCount,
   input  logic                         rdWaitRequest,
   input  logic                         wrWaitRequest,
   output logic                         cmdReady,
   output logic                         rdChipSelect,
   output logic                         rdWrite,
   output logic [`SLAVE_ADDR_WIDTH-1:0] rdAddress,
   output logic [`SLAVE_DATA_WIDTH-1:0] rdWriteData,
   output logic                         wrChipSelect,
   output logic                         wrWrite,
   output logic [`SLAVE_ADDR_WIDTH-1:0] wrAddress,
   output logic [`SLAVE_DATA_WIDTH-1:0] wrWriteData
);

   // submission side, read commands
   logic                    sqPush;
   logic [`ENTRY_WIDTH-1:0] sqEntry;
   logic                    sqCredit;
   logic [`ENTRY_WIDTH-1:0] sqHead;
   logic                    sqEmpty;
   logic                    sqPop;
   // request side, write commands
   logic                    rqPush;
   logic [`ENTRY_WIDTH-1:0] rqEntry;
   logic                    rqCredit;
   logic [`ENTRY_WIDTH-1:0] rqHead;
   logic                    rqEmpty;
   logic                    rqPop;

   cmdRouter router (
      .clock(clock), .reset(reset),
      .cmdValid(cmdValid), .cmdOpcode(cmdOpcode),
      .cmdAddress(cmdAddress), .cmdCount(cmdCount),
      .sqCredit(sqCredit), .rqCredit(rqCredit), .cmdReady(cmdReady),
      .sqPush(sqPush), .sqEntry(sqEntry), .rqPush(rqPush), .rqEntry(rqEntry)
   );

   entryQueue sqQueue (
      .clock(clock), .reset(reset), .push(sqPush), .pushEntry(sqEntry),
      .pop(sqPop), .entry(sqHead), .empty(sqEmpty), .credit(sqCredit)
   );

   entryQueue rqQueue (
      .clock(clock), .reset(reset), .push(rqPush), .pushEntry(rqEntry),
      .pop(rqPop), .entry(rqHead), .empty(rqEmpty), .credit(rqCredit)
   );

   // read engine descriptors
   descriptorWriter #(.statusAddress(`RD_STATUS_ADDR)) rdWriter (
      .clock(clock), .reset(reset), .entry(sqHead), .empty(sqEmpty),
      .waitRequest(rdWaitRequest), .pop(sqPop), .chipSelect(rdChipSelect),
      .write(rdWrite), .address(rdAddress), .writeData(rdWriteData)
   );

   // write engine descriptors
   descriptorWriter #(.statusAddress(`WR_STATUS_ADDR)) wrWriter (
      .clock(clock), .reset(reset), .entry(rqHead), .empty(rqEmpty),
      .waitRequest(wrWaitRequest), .pop(rqPop), .chipSelect(wrChipSelect),
      .write(wrWrite), .address(wrAddress), .writeData(wrWriteData)
   );

endmodule

// File: verilog/entryQueue.sv
`timescale 1ns/1ps
`include "dmaReq_defs.svh"

module entryQueue (
   input  logic                    clock,
   input  logic                    reset,
   input  logic                    push,
   input  logic [`ENTRY_WIDTH-1:0] pushEntry,
   input  logic                    pop,
   output logic [`ENTRY_WIDTH-1:0] entry,
   output logic                    empty,
   output logic                    credit
);

   localparam int ptrWidth = $clog2(`QUEUE_DEPTH);

   logic [`ENTRY_WIDTH-1:0] mem [0:`QUEUE_DEPTH-1];
   logic [ptrWidth-1:0]     rdPtr;
   logic [ptrWidth-1:0]     wrPtr;
   // needs one bit more than the pointers to tell full from empty
   logic [ptrWidth:0]       count;
   logic                    doPop;

   // wrap at the depth, which need not be a power of two
   function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
      logic [ptrWidth-1:0] result;
      result = ptr + 1'b1;
      if (ptr == ptrWidth'(`QUEUE_DEPTH - 1)) begin
         result = '0;
      end
      return result;
   endfunction

   // a pop against an empty queue is ignored
   assign doPop = pop & ~empty;

   // head is visible as soon as it lands
   assign entry = mem[rdPtr];
   assign empty = (count == '0);

   // no full check, the router never sends more than its credits
   always_ff @(posedge clock) begin
      if (push) begin
         mem[wrPtr] <= pushEntry;
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         rdPtr <= '0;
         wrPtr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (doPop) begin
            rdPtr <= nextPtr(rdPtr);
         end
         // occupancy holds when push and pop coincide
         case ({push, doPop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // one credit back per entry leaving
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         credit <= 1'b0;
      end else begin
         credit <= doPop;
      end
   end

endmodule
